//--- Makefile
TOP = tb_exec_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module exec_core
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Architectural state as the testbench expects it, x0 included and never written
exec_pkg::data_t shadow [0:31];
logic [31:0] lcg_state = 32'd88; // Seed of the pseudo random sequence

// Full-period 32-bit LCG, upper bits are the better random ones
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// R-type word: funct7, rs2, rs1, funct3, rd, opcode
function automatic exec_pkg::data_t enc_r(input logic [6:0] funct7,
	input exec_pkg::reg_index_t rs2, input exec_pkg::reg_index_t rs1,
	input logic [2:0] funct3, input exec_pkg::reg_index_t rd);
	return {funct7, rs2, rs1, funct3, rd, exec_pkg::op_reg};
endfunction

// I-type word, shifts carry funct7 in the upper immediate bits
function automatic exec_pkg::data_t enc_i(input logic [11:0] imm,
	input exec_pkg::reg_index_t rs1, input logic [2:0] funct3,
	input exec_pkg::reg_index_t rd);
	return {imm, rs1, funct3, rd, exec_pkg::op_imm};
endfunction

// Legality as RV32I defines it for OP and OP-IMM
function automatic logic ref_legal(input exec_pkg::data_t w);
	logic [6:0] f7;
	logic [2:0] f3;
	f7 = w[31:25];
	f3 = w[14:12];
	if (w[6:0] == 7'b0110011) begin
		return (f7 == 7'b0000000) ||
			((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))); // Only SUB and SRA
	end
	if (w[6:0] == 7'b0010011) begin
		if (f3 == 3'b001) return f7 == 7'b0000000; // SLLI
		if (f3 == 3'b101) return (f7 == 7'b0000000) || (f7 == 7'b0100000); // SRLI, SRAI
		return 1'b1; // Other OP-IMM forms use bits 31:25 as immediate
	end
	return 1'b0;
endfunction

// Expected result read from the shadow registers
function automatic exec_pkg::data_t ref_value(input exec_pkg::data_t w);
	exec_pkg::data_t a;
	exec_pkg::data_t b;
	logic is_imm;
	is_imm = (w[6:0] == 7'b0010011);
	a = shadow[w[19:15]];
	b = is_imm ? {{20{w[31]}}, w[31:20]} : shadow[w[24:20]]; // Sign-extended immediate
	case (w[14:12])
		3'b000: return (!is_imm && w[30]) ? a - b : a + b;
		3'b001: return a << b[4:0]; // Only five shift bits count
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b011: return (a < b) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b101: begin
			if (w[30]) return $signed(a) >>> b[4:0]; // Sign bit fills from the left
			return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

`endif

//--- bench/tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;

	// Strobes per test in run order: reset, addi, r ops, i ops, illegal, chain
	localparam int instr_count = 1 + 33 + 30 + 20 + 34 + 16;
	localparam int watchdog_cycles = instr_count * 3 + 40;

	logic                 clk;
	logic                 reset;
	logic                 instr_valid;
	exec_pkg::data_t      instr;
	logic                 result_valid;
	exec_pkg::reg_index_t result_rd;
	exec_pkg::data_t      result_data;
	logic                 result_zero;
	logic                 illegal;

	int value_errors = 0; // Wrong data, index or flag
	int pulse_errors = 0; // Missing or unexpected pulses

	logic                 exp_legal_q [$]; // Expectations waiting for their pulse
	exec_pkg::reg_index_t exp_rd_q [$];
	exec_pkg::data_t      exp_data_q [$];

	// The ten R-type operations in reference order
	logic [2:0] r_funct3 [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
	logic       r_alt [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

	`include "exec_ref.svh"

	exec_core u_dut (.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.result_valid(result_valid), .result_rd(result_rd), .result_data(result_data),
		.result_zero(result_zero), .illegal(illegal));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

	task automatic check_data(input string name, input exec_pkg::data_t expected,
		input exec_pkg::data_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_index(input string name, input exec_pkg::reg_index_t expected,
		input exec_pkg::reg_index_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: expected x%0d, actual x%0d", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic exec_pkg::reg_index_t pick_reg();
		return exec_pkg::reg_index_t'(1 + (lcg_next() >> 16) % 31); // Never x0
	endfunction

	function automatic exec_pkg::data_t r_word(input int k, input exec_pkg::reg_index_t rs2,
		input exec_pkg::reg_index_t rs1, input exec_pkg::reg_index_t rd);
		return enc_r(r_alt[k] ? 7'b0100000 : 7'b0000000, rs2, rs1, r_funct3[k], rd);
	endfunction

	// Record what the word should produce, then strobe it on the next rising edge
	task automatic drive(input exec_pkg::data_t word);
		logic            legal_exp;
		exec_pkg::data_t value;
		legal_exp = ref_legal(word);
		value = legal_exp ? ref_value(word) : '0;
		exp_legal_q.push_back(legal_exp);
		exp_rd_q.push_back(word[11:7]);
		exp_data_q.push_back(value);
		if (legal_exp && (word[11:7] != 5'd0)) shadow[word[11:7]] = value; // Write-back
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
	endtask

	// Compare the outputs with the oldest expectation
	task automatic check_pending(input string name);
		logic                 legal_exp;
		exec_pkg::reg_index_t rd_exp;
		exec_pkg::data_t      data_exp;
		legal_exp = exp_legal_q.pop_front();
		rd_exp = exp_rd_q.pop_front();
		data_exp = exp_data_q.pop_front();
		if (legal_exp) begin
			if (result_valid !== 1'b1) begin
				pulse_errors++;
				$display("%s: result_valid did not pulse one cycle after the strobe", name);
			end
			if (illegal !== 1'b0) begin
				pulse_errors++;
				$display("%s: illegal pulsed for a legal instruction", name);
			end
			check_index(name, rd_exp, result_rd);
			check_data(name, data_exp, result_data);
			check_flag(name, data_exp == '0, result_zero);
		end else begin
			if (illegal !== 1'b1) begin
				pulse_errors++;
				$display("%s: illegal did not pulse for an illegal instruction", name);
			end
			if (result_valid !== 1'b0) begin
				pulse_errors++;
				$display("%s: result_valid pulsed for an illegal instruction", name);
			end
		end
	endtask

	// Drop the strobe and look at the pulse once the outputs have settled
	task automatic retire(input string name);
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		check_pending(name);
	endtask

	task automatic issue(input string name, input exec_pkg::data_t word);
		drive(word);
		retire(name);
	endtask

	task automatic test_reset_idle();
		repeat (4) begin
			@(negedge clk);
			if ((result_valid !== 1'b0) || (illegal !== 1'b0)) begin
				pulse_errors++;
				$display("reset_idle: output pulse while no instruction was strobed");
			end
		end
		check_data("reset_idle", '0, result_data);
		check_index("reset_idle", '0, result_rd);
		issue("reset_idle", enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3)); // add x3, x1, x2
	endtask

	task automatic test_addi_load();
		logic [31:0] r;
		for (int k = 1; k < 32; k++) begin
			r = lcg_next();
			issue("addi_load", enc_i(r[27:16], 5'd0, 3'b000, exec_pkg::reg_index_t'(k)));
		end
		issue("addi_x0", enc_i(12'h7ff, 5'd1, 3'b000, 5'd0)); // Result shows, no write
		issue("addi_x0_read", enc_i(12'h000, 5'd0, 3'b000, 5'd0)); // x0 must still be zero
	endtask

	task automatic test_r_ops();
		repeat (3) begin
			for (int k = 0; k < 10; k++) begin
				issue("r_ops", r_word(k, pick_reg(), pick_reg(), pick_reg()));
			end
		end
	endtask

	task automatic test_i_ops();
		logic [31:0] r;
		repeat (4) begin
			r = lcg_next();
			issue("slti", enc_i(r[27:16], pick_reg(), 3'b010, pick_reg()));
			issue("sltiu", enc_i(r[19:8], pick_reg(), 3'b011, pick_reg()));
			issue("slli", enc_i({7'b0000000, r[24:20]}, pick_reg(), 3'b001, pick_reg()));
			issue("srli", enc_i({7'b0000000, r[29:25]}, pick_reg(), 3'b101, pick_reg()));
			issue("srai", enc_i({7'b0100000, r[31:27]}, pick_reg(), 3'b101, pick_reg()));
		end
	endtask

	task automatic test_illegal();
		exec_pkg::data_t word;
		word = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd4);
		word[6:0] = 7'b0110111; // LUI is outside this slice
		issue("illegal_opcode", word);
		issue("illegal_funct7", enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd5));
		issue("illegal_xor_alt", enc_r(7'b0100000, 5'd2, 5'd1, 3'b100, 5'd6));
		// Read every register through rd = x0 so nothing is disturbed
		for (int k = 1; k < 32; k++) begin
			issue("illegal_readback", enc_i(12'h000, exec_pkg::reg_index_t'(k), 3'b000, 5'd0));
		end
	endtask

	// One strobe per cycle, each reading the destination of the one before
	task automatic test_chain();
		exec_pkg::reg_index_t prev;
		exec_pkg::reg_index_t rd;
		exec_pkg::data_t      word;
		logic [31:0]          r;
		prev = pick_reg();
		for (int i = 0; i < 16; i++) begin
			rd = pick_reg();
			r = lcg_next();
			if (i % 2 == 0) begin
				word = enc_i(r[27:16], prev, 3'b000, rd);
			end else begin
				word = r_word(int'(r[31:16] % 10), pick_reg(), prev, rd);
			end
			drive(word);
			if (i > 0) begin
				@(negedge clk);
				check_pending("chain"); // Result of the previous strobe
			end
			prev = rd;
		end
		retire("chain");
	endtask

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0; // Reset clears every register
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		test_reset_idle();
		test_addi_load();
		test_r_ops();
		test_i_ops();
		test_illegal();
		test_chain();
		@(negedge clk);
		$display("Value errors: %0d, pulse errors: %0d", value_errors, pulse_errors);
		if ((value_errors == 0) && (pulse_errors == 0)) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+bench
verilog/exec_pkg.sv
verilog/alu.sv
verilog/alu_decode.sv
verilog/reg_file.sv
verilog/exec_core.sv
bench/tb_exec_core.sv

//--- verilog/alu.sv
`timescale 1ns/1ns

module alu (
	input  exec_pkg::alu_op_t op, // Operation chosen by the decoder
	input  exec_pkg::data_t   s1, // First operand, always rs1
	input  exec_pkg::data_t   s2, // Second operand, rs2 or the immediate
	output exec_pkg::data_t   d, // Result of the operation
	output logic              zero_o // High when the result is all zeros
);

	logic [exec_pkg::shamt_width-1:0] shift; // Only the low five bits of s2 count

	assign shift = s2[exec_pkg::shamt_width-1:0]; // Upper bits of s2 are ignored for shifts

	always_comb begin
		case (op)
			exec_pkg::alu_add: begin
				d = s1 + s2; // Wraps around on overflow
			end
			exec_pkg::alu_sub: begin
				d = s1 - s2; // Two's complement difference
			end
			exec_pkg::alu_sll: begin
				d = s1 << shift; // Zeros enter from the right
			end
			exec_pkg::alu_slt: begin
				d = ($signed(s1) < $signed(s2)) ? exec_pkg::data_t'(1) : '0; // Signed less than
			end
			exec_pkg::alu_sltu: begin
				d = (s1 < s2) ? exec_pkg::data_t'(1) : '0; // Unsigned less than
			end
			exec_pkg::alu_xor: begin
				d = s1 ^ s2;
			end
			exec_pkg::alu_srl: begin
				d = s1 >> shift; // Zeros enter from the left
			end
			exec_pkg::alu_sra: begin
				d = $signed(s1) >>> shift; // Copies of the sign bit enter from the left
			end
			exec_pkg::alu_or: begin
				d = s1 | s2;
			end
			exec_pkg::alu_and: begin
				d = s1 & s2;
			end
			default: begin
				d = '0; // Encodings 10 to 15 are not operations
			end
		endcase
	end

	assign zero_o = (d == '0); // Flag follows the result in the same cycle

	// The compares may only ever produce a single low bit
	always_comb begin
		if ((op == exec_pkg::alu_slt) || (op == exec_pkg::alu_sltu)) begin
			assert (d[exec_pkg::xlen-1:1] == '0)
				else $error("alu: compare result is wider than one bit"); // Upper bits must stay clear
		end
	end

endmodule

//--- verilog/alu_decode.sv
`timescale 1ns/1ns

module alu_decode (
	input  exec_pkg::data_t      instr, // Instruction word under decode
	output exec_pkg::reg_index_t rs1, // First source register
	output exec_pkg::reg_index_t rs2, // Second source register, unused by OP-IMM
	output exec_pkg::reg_index_t rd, // Destination register
	output exec_pkg::alu_op_t    alu_op, // Operation for the ALU
	output logic                 use_imm, // Second operand comes from the immediate
	output exec_pkg::data_t      imm, // Sign-extended I-type immediate
	output logic                 legal // Instruction is one this slice can run
);

	exec_pkg::opcode_t opcode; // Major opcode field seen as the enum
	logic [2:0]        funct3; // Selects the operation family
	logic [5:0]        funct7_rest; // funct7 without the alternate bit, must be zero
	logic              alt; // Alternate bit, instruction bit 30
	logic              is_reg; // OP format
	logic              is_imm; // OP-IMM format
	logic              alt_allowed; // This funct3 has an alternate form in this format
	logic              check_funct7; // This format and funct3 carry a real funct7

	assign opcode = exec_pkg::opcode_t'(instr[6:0]); // Other encodings fall out as illegal below
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign alt = instr[exec_pkg::funct7_alt];
	assign funct7_rest = {instr[31], instr[29:25]}; // Every funct7 bit except bit 30

	assign is_reg = (opcode == exec_pkg::op_reg);
	assign is_imm = (opcode == exec_pkg::op_imm);
	assign use_imm = is_imm; // OP-IMM replaces rs2 with the immediate

	// The top immediate bit is copied into every upper position
	assign imm = {{(exec_pkg::xlen-exec_pkg::imm_width){instr[31]}}, instr[31:20]};

	always_comb begin
		alu_op = exec_pkg::alu_add; // Default keeps the output defined
		alt_allowed = 1'b0;
		check_funct7 = is_reg; // In OP every funct3 carries funct7
		case (funct3)
			3'b000: begin
				alu_op = (is_reg && alt) ? exec_pkg::alu_sub : exec_pkg::alu_add; // ADDI has no sub
				alt_allowed = is_reg;
			end
			3'b001: begin
				alu_op = exec_pkg::alu_sll;
				check_funct7 = 1'b1; // SLLI keeps funct7 in the upper bits
			end
			3'b010: alu_op = exec_pkg::alu_slt;
			3'b011: alu_op = exec_pkg::alu_sltu;
			3'b100: alu_op = exec_pkg::alu_xor;
			3'b101: begin
				alu_op = alt ? exec_pkg::alu_sra : exec_pkg::alu_srl; // Both formats have SRA
				alt_allowed = 1'b1;
				check_funct7 = 1'b1; // SRLI and SRAI keep funct7 too
			end
			3'b110: alu_op = exec_pkg::alu_or;
			default: alu_op = exec_pkg::alu_and; // 3'b111
		endcase
	end

	// Non-shift OP-IMM uses bits 31:25 as immediate, so they are not checked there
	assign legal = (is_reg || is_imm) &&
	               (!check_funct7 || ((funct7_rest == '0) && (!alt || alt_allowed)));

endmodule

//--- verilog/exec_core.sv
`timescale 1ns/1ns

module exec_core (
	input  logic                 clk,
	input  logic                 reset, // Synchronous, active high
	input  logic                 instr_valid, // One-cycle strobe for instr
	input  exec_pkg::data_t      instr, // Sampled with instr_valid
	output logic                 result_valid, // Pulses one cycle after a legal strobe
	output exec_pkg::reg_index_t result_rd, // Destination of the result
	output exec_pkg::data_t      result_data, // ALU result
	output logic                 result_zero, // Result was zero
	output logic                 illegal // Pulses one cycle after an illegal strobe
);

	exec_pkg::reg_index_t rs1; // Decoded source and destination registers
	exec_pkg::reg_index_t rs2;
	exec_pkg::reg_index_t rd;
	exec_pkg::alu_op_t    alu_op; // Decoded operation
	logic                 use_imm; // OP-IMM form
	exec_pkg::data_t      imm; // Sign-extended immediate
	logic                 legal; // Decoder accepts the word
	exec_pkg::data_t      rdata1; // Register file read data
	exec_pkg::data_t      rdata2;
	exec_pkg::data_t      operand2; // Second ALU operand after the immediate select
	exec_pkg::data_t      alu_d; // ALU result before the output register
	logic                 alu_zero; // ALU zero flag before the output register
	logic                 accept; // Legal instruction strobed this cycle

	alu_decode u_decode (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .alu_op(alu_op),
		.use_imm(use_imm), .imm(imm), .legal(legal));

	// The write lands on the edge that captures the result, so the next strobe reads it
	reg_file u_reg_file (.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rdata1(rdata1),
		.rdata2(rdata2), .write_enable(accept), .write_index(rd), .write_data(alu_d));

	assign operand2 = use_imm ? imm : rdata2; // Immediate replaces rs2 for OP-IMM

	alu u_alu (.op(alu_op), .s1(rdata1), .s2(operand2), .d(alu_d), .zero_o(alu_zero));

	assign accept = instr_valid && legal;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			illegal <= 1'b0;
			result_rd <= '0;
			result_data <= '0;
			result_zero <= 1'b0;
		end else begin
			result_valid <= accept; // High for exactly one cycle per strobe
			illegal <= instr_valid && !legal;
			if (accept) begin
				result_rd <= rd; // Held until the next legal instruction
				result_data <= alu_d; // Same value as the register file write
				result_zero <= alu_zero;
			end
		end
	end

	// Each strobe yields one outcome and never both
	a_one_outcome: assert property (
		@(posedge clk) disable iff (reset) !(result_valid && illegal)
	) else $error("exec_core: result_valid and illegal together");

endmodule

//--- verilog/exec_pkg.sv
package exec_pkg;

	// Data path width of the RV32I slice
	localparam int xlen = 32; // Operands, results and immediates all use this width
	localparam int reg_index_width = 5; // Enough bits to name x0 to x31
	localparam int reg_count = 32; // Architectural registers including x0
	localparam int shamt_width = 5; // Shift amount taken from the low bits of s2
	localparam int imm_width = 12; // Width of the I-type immediate field

	// Instruction bit that picks the alternate form (sub, sra)
	localparam int funct7_alt = 30; // Bit 5 of funct7 inside the instruction word

	typedef logic [xlen-1:0] data_t; // Operand, result and immediate word
	typedef logic [reg_index_width-1:0] reg_index_t; // Register number

	// ALU operations, numbered the same way as the original ALU encoding
	typedef enum logic [3:0] {
		alu_add  = 4'd0, // s1 + s2
		alu_sub  = 4'd1, // s1 - s2
		alu_sll  = 4'd2, // Logical left shift
		alu_slt  = 4'd3, // Signed compare, result is 0 or 1
		alu_sltu = 4'd4, // Unsigned compare, result is 0 or 1
		alu_xor  = 4'd5, // Bitwise exclusive or
		alu_srl  = 4'd6, // Logical right shift
		alu_sra  = 4'd7, // Arithmetic right shift keeps the sign
		alu_or   = 4'd8, // Bitwise or
		alu_and  = 4'd9  // Bitwise and
	} alu_op_t;

	// Major opcodes handled by this slice
	typedef enum logic [6:0] {
		op_reg = 7'b0110011, // Register-register arithmetic (OP)
		op_imm = 7'b0010011  // Register-immediate arithmetic (OP-IMM)
	} opcode_t;

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                 clk,
	input  logic                 reset, // Synchronous, clears every register
	input  exec_pkg::reg_index_t rs1, // Read port 1 address
	input  exec_pkg::reg_index_t rs2, // Read port 2 address
	output exec_pkg::data_t      rdata1, // Read port 1 data, combinational
	output exec_pkg::data_t      rdata2, // Read port 2 data, combinational
	input  logic                 write_enable, // Write on the next rising edge
	input  exec_pkg::reg_index_t write_index, // Destination of the write
	input  exec_pkg::data_t      write_data // Value to store
);

	// x0 has no storage, only x1 to x31 exist
	exec_pkg::data_t regs [1:exec_pkg::reg_count-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < exec_pkg::reg_count; i++) begin
				regs[i] <= '0; // All registers read zero after reset
			end
		end else if (write_enable && (write_index != '0)) begin
			regs[write_index] <= write_data; // Writes to x0 are dropped here
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 is hardwired to zero
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	// Both read ports return zero for x0 in every cycle
	a_x0_always_zero: assert property (
		@(posedge clk) disable iff (reset)
		((rs1 != '0) || (rdata1 == '0)) && ((rs2 != '0) || (rdata2 == '0))
	) else $error("reg_file: x0 is not zero");

endmodule
